//--- hw/mem_addr_decoder.sv
// Address decoder that steers bus strobes to one bank and registers the select.
`timescale 1ns/1ps

module mem_addr_decoder #(
    // Number of banks, at least 2.
    parameter int bank_count = 4,
    // Words per bank, a power of two.
    parameter int bank_words = 64,
    // Offset bits inside one bank.
    localparam int off_bits = $clog2(bank_words)
) (
    input  logic                       clk,
    input  logic                       rst,
    // Shared bus side.
    input  logic                       bus_re,
    input  mem_fabric_pkg::strb_t      bus_we,
    input  mem_fabric_pkg::word_addr_t bus_addr,
    input  mem_fabric_pkg::data_t      bus_wdata,
    // Bank side.
    output logic                       bank_re [bank_count],
    output mem_fabric_pkg::strb_t      bank_we [bank_count],
    output logic [off_bits-1:0]        bank_addr,
    output mem_fabric_pkg::data_t      bank_wdata,
    // Select for the response phase.
    output logic [bank_count-1:0]      sel_q
);

    // Address bits above the bank offset.
    localparam int idx_bits = $bits(mem_fabric_pkg::word_addr_t) - off_bits;

    logic [idx_bits-1:0]   bank_idx;
    logic [bank_count-1:0] sel;
    logic                  access;

    assign bank_idx = bus_addr[$bits(mem_fabric_pkg::word_addr_t)-1:off_bits];
    assign access   = bus_re || (|bus_we);

    // One-hot bank select, empty above the last bank.
    always_comb begin
        sel = '0;
        for (int k = 0; k < bank_count; k++) begin
            if (bank_idx == idx_bits'(k)) begin
                sel[k] = 1'b1;
            end
        end
    end

    // Strobes reach only the selected bank.
    always_comb begin
        for (int k = 0; k < bank_count; k++) begin
            bank_re[k] = sel[k] && bus_re;
            bank_we[k] = sel[k] ? bus_we : '0;
        end
    end

    assign bank_addr  = bus_addr[off_bits-1:0];
    assign bank_wdata = bus_wdata;

    // Zero when idle, so the merger returns no stale bank.
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else begin
            sel_q <= access ? sel : '0;
        end
    end

endmodule

//--- hw/mem_arbiter_rr.sv
// Round-robin arbiter that grants the first requester found after the current owner.
`timescale 1ns/1ps

module mem_arbiter_rr #(
    // Number of competing ports, at least 2.
    parameter int ports = 2
) (
    // Request level per port.
    input  logic [ports-1:0] req,
    // Current owner, one-hot.
    input  logic [ports-1:0] cur,
    // Grant, one-hot or zero without requests.
    output logic [ports-1:0] next
);

    always_comb begin
        int   owner;
        int   idx;
        logic found;
        // Locate the current owner.
        owner = 0;
        for (int i = 0; i < ports; i++) begin
            if (cur[i]) begin
                owner = i;
            end
        end
        // Scan cyclically, owner itself comes last.
        next  = '0;
        found = 1'b0;
        for (int k = 1; k <= ports; k++) begin
            idx = (owner + k) % ports;
            if (!found && req[idx]) begin
                next[idx] = 1'b1;
                found     = 1'b1;
            end
        end
    end

endmodule

//--- hw/mem_bank.sv
// Single RAM bank with byte write enables and one-cycle read latency.
`timescale 1ns/1ps

module mem_bank #(
    // Words in this bank, a power of two.
    parameter int bank_words = 64,
    // Offset bits inside the bank.
    localparam int off_bits = $clog2(bank_words)
) (
    input  logic                  clk,
    // Read enable.
    input  logic                  re,
    // Byte write enables.
    input  mem_fabric_pkg::strb_t we,
    // Word offset in the bank.
    input  logic [off_bits-1:0]   addr,
    // Write data.
    input  mem_fabric_pkg::data_t wdata,
    // Registered read data.
    output mem_fabric_pkg::data_t rdata
);

    // Storage array.
    mem_fabric_pkg::data_t mem [bank_words];

    // Byte lanes are written independently.
    always_ff @(posedge clk) begin
        for (int b = 0; b < mem_fabric_pkg::bytes_per_word; b++) begin
            if (we[b]) begin
                mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // Read returns the word as it was before this edge.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- hw/mem_bus_demux.sv
// Bus demultiplexer that holds custody and merges the granted CPU onto the shared bus.
`timescale 1ns/1ps

module mem_bus_demux #(
    // Number of CPU ports, at least 2.
    parameter int cpu_count = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    // CPU side.
    input  logic                       cpu_re    [cpu_count],
    input  mem_fabric_pkg::strb_t      cpu_we    [cpu_count],
    input  mem_fabric_pkg::word_addr_t cpu_addr  [cpu_count],
    input  mem_fabric_pkg::data_t      cpu_wdata [cpu_count],
    output logic                       cpu_ready [cpu_count],
    output mem_fabric_pkg::data_t      cpu_rdata [cpu_count],
    // Shared bus side.
    output logic                       bus_re,
    output mem_fabric_pkg::strb_t      bus_we,
    output mem_fabric_pkg::word_addr_t bus_addr,
    output mem_fabric_pkg::data_t      bus_wdata,
    input  logic                       bus_ready,
    input  mem_fabric_pkg::data_t      bus_rdata
);

    // Request level per CPU.
    logic [cpu_count-1:0] req;
    // Custodian of the bus, one-hot.
    logic [cpu_count-1:0] cur;
    // Arbiter choice when the custodian lets go.
    logic [cpu_count-1:0] next;
    // CPU driving the bus this cycle.
    logic [cpu_count-1:0] next_cpu;

    always_comb begin
        for (int i = 0; i < cpu_count; i++) begin
            req[i] = cpu_re[i] || (|cpu_we[i]);
        end
    end

    mem_arbiter_rr #(
        .ports(cpu_count)
    ) u_arbiter (
        .req (req),
        .cur (cur),
        .next(next)
    );

    // Owner keeps the bus while it still requests.
    assign next_cpu = (|(cur & req)) ? cur : next;

    // Custody register, CPU 0 owns the bus after reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            cur <= cpu_count'(1);
        end else if (next_cpu != '0) begin
            cur <= next_cpu;
        end
    end

    // Only the granted CPU reaches the bus.
    always_comb begin
        bus_re    = 1'b0;
        bus_we    = '0;
        bus_addr  = '0;
        bus_wdata = '0;
        for (int i = 0; i < cpu_count; i++) begin
            if (next_cpu[i]) begin
                bus_re    |= cpu_re[i];
                bus_we    |= cpu_we[i];
                bus_addr  |= cpu_addr[i];
                bus_wdata |= cpu_wdata[i];
            end
        end
    end

    // Response goes to whoever held the bus last cycle.
    always_comb begin
        for (int i = 0; i < cpu_count; i++) begin
            cpu_ready[i] = cur[i] && bus_ready;
            cpu_rdata[i] = bus_rdata;
        end
    end

endmodule

//--- hw/mem_fabric_pkg.sv
// Memory fabric package with the shared word, strobe and address types and default sizes.
package mem_fabric_pkg;

    // One data word on the bus.
    typedef logic [31:0] data_t;

    // Byte write enables, one per byte lane.
    typedef logic [3:0] strb_t;

    // Word address, byte address bits above bit 1.
    typedef logic [13:0] word_addr_t;

    // Default number of CPU ports.
    localparam int default_cpu_count = 2;

    // Default number of RAM banks.
    localparam int default_bank_count = 4;

    // Default words per bank, a power of two.
    localparam int default_bank_words = 64;

    // Bytes in one data word.
    localparam int bytes_per_word = $bits(strb_t);

endpackage

//--- hw/mem_fabric_top.sv
// Memory fabric top level joining CPU ports, arbitration, decode, banks and response merge.
`timescale 1ns/1ps

module mem_fabric_top #(
    parameter int cpu_count  = mem_fabric_pkg::default_cpu_count,
    parameter int bank_count = mem_fabric_pkg::default_bank_count,
    parameter int bank_words = mem_fabric_pkg::default_bank_words
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_re    [cpu_count],
    input  mem_fabric_pkg::strb_t      cpu_we    [cpu_count],
    input  mem_fabric_pkg::word_addr_t cpu_addr  [cpu_count],
    input  mem_fabric_pkg::data_t      cpu_wdata [cpu_count],
    output logic                       cpu_ready [cpu_count],
    output mem_fabric_pkg::data_t      cpu_rdata [cpu_count]
);

    localparam int off_bits = $clog2(bank_words);

    // Shared bus after arbitration.
    logic                       bus_re;
    mem_fabric_pkg::strb_t      bus_we;
    mem_fabric_pkg::word_addr_t bus_addr;
    mem_fabric_pkg::data_t      bus_wdata;
    logic                       bus_ready;
    mem_fabric_pkg::data_t      bus_rdata;

    // Bank side.
    logic                       bank_re    [bank_count];
    mem_fabric_pkg::strb_t      bank_we    [bank_count];
    logic [off_bits-1:0]        bank_addr;
    mem_fabric_pkg::data_t      bank_wdata;
    mem_fabric_pkg::data_t      bank_rdata [bank_count];
    logic [bank_count-1:0]      sel_q;

    mem_bus_demux #(
        .cpu_count(cpu_count)
    ) u_demux (
        .clk      (clk),
        .rst      (rst),
        .cpu_re   (cpu_re),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_ready(cpu_ready),
        .cpu_rdata(cpu_rdata),
        .bus_re   (bus_re),
        .bus_we   (bus_we),
        .bus_addr (bus_addr),
        .bus_wdata(bus_wdata),
        .bus_ready(bus_ready),
        .bus_rdata(bus_rdata)
    );

    mem_addr_decoder #(
        .bank_count(bank_count),
        .bank_words(bank_words)
    ) u_decoder (
        .clk       (clk),
        .rst       (rst),
        .bus_re    (bus_re),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bank_re   (bank_re),
        .bank_we   (bank_we),
        .bank_addr (bank_addr),
        .bank_wdata(bank_wdata),
        .sel_q     (sel_q)
    );

    // One RAM per bank, all sharing offset and write data.
    for (genvar k = 0; k < bank_count; k++) begin : g_bank
        mem_bank #(
            .bank_words(bank_words)
        ) u_bank (
            .clk  (clk),
            .re   (bank_re[k]),
            .we   (bank_we[k]),
            .addr (bank_addr),
            .wdata(bank_wdata),
            .rdata(bank_rdata[k])
        );
    end

    mem_resp_merge #(
        .bank_count(bank_count)
    ) u_merge (
        .sel_q     (sel_q),
        .bank_rdata(bank_rdata),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata)
    );

endmodule

//--- hw/mem_resp_merge.sv
// Response merger that returns the selected bank's read data and a constant ready.
`timescale 1ns/1ps

module mem_resp_merge #(
    // Number of banks, at least 2.
    parameter int bank_count = 4
) (
    // Registered bank select, one-hot or zero.
    input  logic [bank_count-1:0] sel_q,
    // Read data per bank.
    input  mem_fabric_pkg::data_t bank_rdata [bank_count],
    // Ready back to the demux.
    output logic                  bus_ready,
    // Merged read data.
    output mem_fabric_pkg::data_t bus_rdata
);

    // Banks never stall.
    assign bus_ready = 1'b1;

    // OR of the enabled banks.
    // Empty select leaves zero, covering unmapped reads.
    always_comb begin
        bus_rdata = '0;
        for (int k = 0; k < bank_count; k++) begin
            if (sel_q[k]) begin
                bus_rdata |= bank_rdata[k];
            end
        end
    end

endmodule

//--- sim/mem_fabric_assertions.sv
// Bound checks on ready and bank strobe exclusivity and on bank address ranges.
`timescale 1ns/1ps

module mem_fabric_assertions #(
    parameter int cpu_count  = 2,
    parameter int bank_count = 4,
    parameter int bank_words = 64
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       cpu_ready [cpu_count],
    input logic                       bank_re   [bank_count],
    input mem_fabric_pkg::strb_t      bank_we   [bank_count],
    input mem_fabric_pkg::word_addr_t bus_addr
);

    logic [cpu_count-1:0]  ready_vec;
    logic [bank_count-1:0] bank_act;
    // Failed assertion count, summed into the testbench verdict.
    int                    failures = 0;

    // Packed views of the port arrays.
    always_comb begin
        for (int i = 0; i < cpu_count; i++) begin
            ready_vec[i] = cpu_ready[i];
        end
        for (int k = 0; k < bank_count; k++) begin
            bank_act[k] = bank_re[k] || (|bank_we[k]);
        end
    end

    // Custody is one-hot, so ready reaches one CPU at most.
    ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ready_vec))
        else begin
            $error("more than one cpu_ready high");
            failures++;
        end

    bank_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(bank_act))
        else begin
            $error("more than one bank strobed");
            failures++;
        end

    // A strobed bank must own the bus address.
    for (genvar k = 0; k < bank_count; k++) begin : g_range
        bank_range: assert property (@(posedge clk) disable iff (rst)
            bank_act[k] |-> (int'(bus_addr) / bank_words == k))
            else begin
                $error("bank %0d strobed for word %h", k, bus_addr);
                failures++;
            end
    end

endmodule

//--- sim/mem_fabric_checker.sv
// Checker that tracks accepted CPU accesses in a reference memory and compares read data.
`timescale 1ns/1ps

module mem_fabric_checker #(
    parameter int cpu_count  = 2,
    parameter int bank_count = 4,
    parameter int bank_words = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_re    [cpu_count],
    input  mem_fabric_pkg::strb_t      cpu_we    [cpu_count],
    input  mem_fabric_pkg::word_addr_t cpu_addr  [cpu_count],
    input  mem_fabric_pkg::data_t      cpu_wdata [cpu_count],
    input  logic                       cpu_ready [cpu_count],
    input  mem_fabric_pkg::data_t      cpu_rdata [cpu_count],
    output int                         errors,
    output int                         accepted
);

    localparam int mapped_words = bank_count * bank_words;
    // Longest wait allowed for a refused request.
    localparam int max_wait = 64;

    // Reference memory over all mapped words.
    mem_fabric_pkg::data_t      model [mapped_words];
    // Request seen in the previous cycle.
    logic                       pend       [cpu_count];
    logic                       pend_re    [cpu_count];
    mem_fabric_pkg::strb_t      pend_we    [cpu_count];
    mem_fabric_pkg::word_addr_t pend_addr  [cpu_count];
    mem_fabric_pkg::data_t      pend_wdata [cpu_count];
    // Cycles since a request was first refused.
    int                         age [cpu_count];

    // Returns the word before the access, then merges written bytes.
    function automatic mem_fabric_pkg::data_t ref_access(input mem_fabric_pkg::strb_t we,
                                                         input mem_fabric_pkg::word_addr_t addr,
                                                         input mem_fabric_pkg::data_t wdata);
        mem_fabric_pkg::data_t old;
        // Unmapped reads give zero, writes vanish.
        if (int'(addr) >= mapped_words) begin
            return '0;
        end
        old = model[addr];
        for (int b = 0; b < mem_fabric_pkg::bytes_per_word; b++) begin
            if (we[b]) begin
                model[addr][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return old;
    endfunction

    initial begin
        foreach (model[w]) begin
            model[w] = '0;
        end
    end

    // Sampled mid-cycle, away from the driving edge.
    always @(negedge clk) begin
        mem_fabric_pkg::data_t expected;
        if (rst) begin
            errors   = 0;
            accepted = 0;
            for (int i = 0; i < cpu_count; i++) begin
                pend[i] = 1'b0;
                age[i]  = 0;
            end
        end else begin
            for (int i = 0; i < cpu_count; i++) begin
                // Ready now answers last cycle's request.
                if (pend[i] && cpu_ready[i]) begin
                    accepted++;
                    age[i]   = 0;
                    expected = ref_access(pend_we[i], pend_addr[i], pend_wdata[i]);
                    if (pend_re[i] && cpu_rdata[i] !== expected) begin
                        errors++;
                        $display("MISMATCH cpu_rdata[%0d] word %h: expected %h, got %h",
                                 i, pend_addr[i], expected, cpu_rdata[i]);
                    end
                end else if (pend[i] || age[i] > 0) begin
                    age[i]++;
                    if (age[i] == max_wait) begin
                        errors++;
                        $display("cpu %0d: request for word %h not served within %0d cycles",
                                 i, pend_addr[i], max_wait);
                    end
                end
                pend[i]       = cpu_re[i] || (|cpu_we[i]);
                pend_re[i]    = cpu_re[i];
                pend_we[i]    = cpu_we[i];
                pend_addr[i]  = cpu_addr[i];
                pend_wdata[i] = cpu_wdata[i];
            end
        end
    end

endmodule

//--- sim/mem_fabric_tb.sv
// Testbench for the memory fabric with directed and seeded random traffic from two CPUs.
`timescale 1ns/1ps

module mem_fabric_tb;

    localparam int cpu_count    = mem_fabric_pkg::default_cpu_count;
    localparam int bank_count   = mem_fabric_pkg::default_bank_count;
    localparam int bank_words   = mem_fabric_pkg::default_bank_words;
    localparam int mapped_words = bank_count * bank_words;
    localparam int random_ops   = 400;
    // Directed tests, then at worst 4 cycles per random access.
    localparam int timeout_cycles = 800 + cpu_count * random_ops * 4;

    logic                       clk;
    logic                       rst;
    logic                       cpu_re    [cpu_count];
    mem_fabric_pkg::strb_t      cpu_we    [cpu_count];
    mem_fabric_pkg::word_addr_t cpu_addr  [cpu_count];
    mem_fabric_pkg::data_t      cpu_wdata [cpu_count];
    logic                       cpu_ready [cpu_count];
    mem_fabric_pkg::data_t      cpu_rdata [cpu_count];

    int chk_errors;
    int accepted;
    int cycle = 0;
    int tb_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_mark = 0;
    int tb_mark = 0;
    int sva_mark = 0;
    // Attempts and finishing cycle of the last access per CPU.
    int tries [cpu_count];
    int stamp [cpu_count];

    mem_fabric_top dut0 (.*);

    mem_fabric_checker #(
        .cpu_count (cpu_count),
        .bank_count(bank_count),
        .bank_words(bank_words)
    ) chk0 (
        .*,
        .errors  (chk_errors),
        .accepted(accepted)
    );

    bind mem_fabric_top mem_fabric_assertions #(
        .cpu_count (cpu_count),
        .bank_count(bank_count),
        .bank_words(bank_words)
    ) u_assertions (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Word pattern built from the whole address.
    function automatic mem_fabric_pkg::data_t pattern(input mem_fabric_pkg::word_addr_t addr,
                                                      input int salt);
        return {addr[7:0] ^ 8'(salt), ~addr[7:0], addr, 2'b01};
    endfunction

    // Present for one cycle, look at ready in the next, retry if refused.
    task automatic access(input int cpu, input logic re, input mem_fabric_pkg::strb_t we,
                          input mem_fabric_pkg::word_addr_t addr,
                          input mem_fabric_pkg::data_t wdata,
                          output int n_tries, output int n_stamp);
        logic served;
        served  = 1'b0;
        n_tries = 0;
        while (!served) begin
            @(posedge clk);
            cpu_re[cpu]    <= re;
            cpu_we[cpu]    <= we;
            cpu_addr[cpu]  <= addr;
            cpu_wdata[cpu] <= wdata;
            n_tries++;
            @(posedge clk);
            cpu_re[cpu] <= 1'b0;
            cpu_we[cpu] <= '0;
            @(negedge clk);
            served = cpu_ready[cpu];
        end
        n_stamp = cycle;
    endtask

    // Mixed reads and writes over bank edges and unmapped space.
    task automatic random_traffic(input int cpu);
        logic                       re;
        mem_fabric_pkg::strb_t      we;
        mem_fabric_pkg::word_addr_t addr;
        int                         n_tries;
        int                         n_stamp;
        for (int n = 0; n < random_ops; n++) begin
            re = 1'($urandom % 2);
            we = re ? '0 : mem_fabric_pkg::strb_t'($urandom % 15 + 1);
            if ($urandom % 4 != 0) begin
                addr = mem_fabric_pkg::word_addr_t'(($urandom % bank_count) * bank_words
                                                    + ($urandom % 2) * (bank_words - 1));
            end else begin
                addr = mem_fabric_pkg::word_addr_t'(mapped_words + $urandom
                       % (2 ** $bits(mem_fabric_pkg::word_addr_t) - mapped_words));
            end
            repeat ($urandom % 2) @(posedge clk);
            access(cpu, re, we, addr, $urandom, n_tries, n_stamp);
        end
    endtask

    // Verdict of one test from the errors counted since the previous one.
    task automatic finish_test(input string name);
        int bad;
        @(posedge clk);
        bad = (chk_errors - err_mark) + (tb_errors - tb_mark)
              + (dut0.u_assertions.failures - sva_mark);
        tests_run++;
        if (bad == 0) begin
            $display("%s: PASS", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, bad);
        end
        err_mark = chk_errors;
        tb_mark  = tb_errors;
        sva_mark = dut0.u_assertions.failures;
    endtask

    initial begin
        mem_fabric_pkg::word_addr_t a;
        int                         total;
        void'($urandom(32'h3de2_da4a));
        rst = 1'b1;
        for (int i = 0; i < cpu_count; i++) begin
            cpu_re[i]    = 1'b0;
            cpu_we[i]    = '0;
            cpu_addr[i]  = '0;
            cpu_wdata[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // First and last word of each bank, full write then partial.
        for (int k = 0; k < bank_count; k++) begin
            for (int e = 0; e < 2; e++) begin
                a = mem_fabric_pkg::word_addr_t'(k * bank_words + e * (bank_words - 1));
                access(0, 1'b0, 4'hf, a, pattern(a, 0), tries[0], stamp[0]);
                access(0, 1'b0, mem_fabric_pkg::strb_t'((2 * k + e) % 14 + 1), a,
                       pattern(a, k + 1), tries[0], stamp[0]);
            end
        end
        for (int k = 0; k < bank_count; k++) begin
            for (int e = 0; e < 2; e++) begin
                a = mem_fabric_pkg::word_addr_t'(k * bank_words + e * (bank_words - 1));
                access(0, 1'b1, '0, a, '0, tries[0], stamp[0]);
            end
        end
        finish_test("bank coverage");

        // Beyond the last bank, then bank 0 must be untouched.
        a = mem_fabric_pkg::word_addr_t'(mapped_words);
        access(0, 1'b0, 4'hf, a, 32'hdead_beef, tries[0], stamp[0]);
        access(0, 1'b0, 4'hf, 14'h3fff, 32'hcafe_f00d, tries[0], stamp[0]);
        access(0, 1'b1, '0, a, '0, tries[0], stamp[0]);
        if (tries[0] != 1) begin
            tb_errors++;
            $display("unmapped read was not answered in the next cycle");
        end
        access(0, 1'b1, '0, 14'h3fff, '0, tries[0], stamp[0]);
        access(0, 1'b1, '0, '0, '0, tries[0], stamp[0]);
        finish_test("unmapped addresses");

        // Both CPUs in the same cycle.
        fork
            access(0, 1'b0, 4'hf, 14'(bank_words), pattern(14'(bank_words), 7),
                   tries[0], stamp[0]);
            access(1, 1'b1, '0, 14'(3 * bank_words - 1), '0, tries[1], stamp[1]);
        join
        if ((tries[0] == 1) == (tries[1] == 1)) begin
            tb_errors++;
            $display("contention: expected one CPU served at once, tries were %0d and %0d",
                     tries[0], tries[1]);
        end
        finish_test("contention");

        // CPU 0 takes custody, keeps it for three accesses, then lets go.
        access(0, 1'b1, '0, '0, '0, tries[0], stamp[0]);
        fork
            for (int n = 0; n < 3; n++) begin
                access(0, 1'b0, 4'hf, 14'(n), pattern(14'(n), 9), tries[0], stamp[0]);
            end
            access(1, 1'b1, '0, 14'(1), '0, tries[1], stamp[1]);
        join
        if (tries[1] < 2 || stamp[1] <= stamp[0] || stamp[1] > stamp[0] + 2) begin
            tb_errors++;
            $display("round robin: cpu 1 served at cycle %0d, cpu 0 released at cycle %0d",
                     stamp[1], stamp[0]);
        end
        finish_test("round robin order");

        fork
            random_traffic(0);
            random_traffic(1);
        join
        finish_test("random traffic");

        total = chk_errors + tb_errors + dut0.u_assertions.failures;
        $display("summary: %0d tests, %0d failing, %0d accesses accepted, %0d errors",
                 tests_run, tests_failed, accepted, total);
        if (tests_failed == 0 && total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Run limit.
    initial begin
        while (cycle < timeout_cycles) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("test failed");
        $finish;
    end

endmodule

//--- src.f
hw/mem_fabric_pkg.sv
hw/mem_arbiter_rr.sv
hw/mem_bus_demux.sv
hw/mem_addr_decoder.sv
hw/mem_bank.sv
hw/mem_resp_merge.sv
hw/mem_fabric_top.sv
sim/mem_fabric_assertions.sv
sim/mem_fabric_checker.sv
sim/mem_fabric_tb.sv
